// File: common/FixedPointPkg.sv
//------------------------------
// Fixed-point add unit package
// Opcodes and default datapath width
//------------------------------
`default_nettype none

package FixedPointPkg;

    //------------------------------
    // Datapath width
    //------------------------------
    // Golden vectors are written for 16-bit words
    localparam int DefaultDataWidth = 16;

    //------------------------------
    // Operation codes
    //------------------------------
    // Bit 0 selects subtract, bit 1 selects saturation
    typedef enum logic [1:0] {
        OpAdd    = 2'b00, // Wrapping add
        OpSub    = 2'b01, // Wrapping subtract
        OpAddSat = 2'b10, // Add, clamp on signed overflow
        OpSubSat = 2'b11  // Subtract, clamp on signed overflow
    } opcodeE;

    // Subtract is done as a + ~b + 1 in the adder chain
    // Clamp target depends only on the sign of operand A
    // Raw carry out is reported for every opcode

endpackage : FixedPointPkg

`default_nettype wire

// File: StructuralRippleCarryAdd/StructuralFullAdd.sv
//------------------------------
// One-bit full adder cell
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module StructuralFullAdd (
    input  logic a,  // Operand A bit
    input  logic b,  // Operand B bit
    input  logic ci, // Carry in
    output logic c,  // Sum bit
    output logic co  // Carry out
);

    logic halfSum; // Propagate term

    assign halfSum = a ^ b;
    assign c       = halfSum ^ ci;

    // Generate or propagate
    assign co = (a & b) | (ci & halfSum);

endmodule : StructuralFullAdd

`default_nettype wire

// File: StructuralRippleCarryAdd/StructuralRippleCarryAdd.sv
//------------------------------
// Ripple-carry adder
// Chain of full-add cells, carry rippling from LSB to MSB
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module StructuralRippleCarryAdd #(
    parameter int N = 32           // Datapath width in bits
) (
    input  logic [N-1:0] a,        // Operand A
    input  logic [N-1:0] b,        // Operand B
    input  logic         ci,       // Carry in
    output logic [N-1:0] c,        // Sum
    output logic         co        // Carry out of MSB
);

    //------------------------------
    // Carry chain
    //------------------------------
    logic [N:0] cx; // cx[i] feeds cell i

    assign cx[0] = ci;
    assign co    = cx[N];

    //------------------------------
    // Full-add cells
    //------------------------------
    genvar i;
    generate
        for (i = 0; i < N; i = i + 1) begin : gFullAdd
            StructuralFullAdd uFullAdd (
                .a  (a[i]),
                .b  (b[i]),
                .ci (cx[i]),
                .c  (c[i]),
                .co (cx[i+1])  // Ripples into next cell
            );
        end : gFullAdd
    endgenerate

    // Purely combinational
    // Worst-case path runs through all N cells

endmodule : StructuralRippleCarryAdd

`default_nettype wire

// File: hdl/AddOperandPrep.sv
//------------------------------
// Operand preparation stage
// Opcode decode, B inversion and carry in, one register stage
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module AddOperandPrep #(
    parameter int DataWidth = FixedPointPkg::DefaultDataWidth
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [DataWidth-1:0]  a,
    input  logic [DataWidth-1:0]  b,
    input  FixedPointPkg::opcodeE op,
    input  logic                  inValid,   // Capture strobe
    output logic [DataWidth-1:0]  prepA,
    output logic [DataWidth-1:0]  prepB,     // Inverted for subtract
    output logic                  prepCarry, // Adder carry in
    output logic                  prepSat,   // Saturating opcode
    output logic                  prepSignA,
    output logic                  prepValid
);

    logic isSub; // Invert B and add one
    logic isSat;

    // Opcode decode
    always_comb begin
        isSub = 1'b0;
        isSat = 1'b0;
        case (op)
            FixedPointPkg::OpAdd:    isSub = 1'b0;
            FixedPointPkg::OpSub:    isSub = 1'b1;
            FixedPointPkg::OpAddSat: isSat = 1'b1;
            FixedPointPkg::OpSubSat: begin
                isSub = 1'b1;
                isSat = 1'b1;
            end
            default: isSub = 1'b0;
        endcase
    end

    //------------------------------
    // Stage one registers
    //------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            prepValid <= 1'b0;
        end else begin
            prepValid <= inValid; // One-cycle pulse follows input
        end
    end

    // Operands hold between strobes
    always_ff @(posedge clk) begin
        if (inValid) begin
            prepA     <= a;
            prepB     <= isSub ? ~b : b;
            prepCarry <= isSub;
            prepSat   <= isSat;
            prepSignA <= a[DataWidth-1];
        end
    end

    // Opcode must be clean whenever a vector is captured
    assert property (@(posedge clk) disable iff (!arstN) inValid |-> !$isunknown(op));

endmodule : AddOperandPrep

`default_nettype wire

// File: hdl/AddResultStage.sv
//------------------------------
// Result stage
// Signed overflow, saturation and output register
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module AddResultStage #(
    parameter int DataWidth = FixedPointPkg::DefaultDataWidth
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [DataWidth-1:0] prepA,     // Adder operand A
    input  logic [DataWidth-1:0] prepB,     // Adder operand B after inversion
    input  logic [DataWidth-1:0] sum,       // From ripple adder
    input  logic                 sumCarry,  // Raw carry out of adder
    input  logic                 prepSat,
    input  logic                 prepSignA, // Picks clamp direction
    input  logic                 prepValid,
    output logic [DataWidth-1:0] result,
    output logic                 carryOut,
    output logic                 overflow,
    output logic                 outValid
);

    //------------------------------
    // Clamp values
    //------------------------------
    localparam logic [DataWidth-1:0] MaxPos = {1'b0, {(DataWidth-1){1'b1}}};
    localparam logic [DataWidth-1:0] MinNeg = {1'b1, {(DataWidth-1){1'b0}}};

    logic                 signA;
    logic                 signB;
    logic                 signSum;
    logic                 ovf;        // Signed overflow of this vector
    logic [DataWidth-1:0] satValue;
    logic [DataWidth-1:0] nextResult;

    assign signA   = prepA[DataWidth-1];
    assign signB   = prepB[DataWidth-1];
    assign signSum = sum[DataWidth-1];

    // Same operand signs but sum sign flipped
    assign ovf = (signA == signB) && (signSum != signA);

    assign satValue   = prepSignA ? MinNeg : MaxPos;
    assign nextResult = (prepSat && ovf) ? satValue : sum;

    //------------------------------
    // Stage two registers
    //------------------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            result   <= '0;
            carryOut <= 1'b0;
            overflow <= 1'b0;
            outValid <= 1'b0;
        end else begin
            outValid <= prepValid;
            if (prepValid) begin  // Outputs hold until next vector
                result   <= nextResult;
                carryOut <= sumCarry;
                overflow <= ovf;
            end
        end
    end

    //------------------------------
    // Checks
    //------------------------------
    assert property (@(posedge clk) disable iff (!arstN) !$isunknown(outValid));

    // Clamp direction opposes the sign of the wrapped sum
    assert property (@(posedge clk) disable iff (!arstN)
        (prepValid && prepSat && ovf) |=>
            (result == ($past(signSum) ? MaxPos : MinNeg)));

endmodule : AddResultStage

`default_nettype wire

// File: hdl/FixedPointAddUnit.sv
//------------------------------
// Fixed-point add/subtract unit
// Two-cycle pipeline around a ripple-carry adder
// Wrap or saturate, with carry and signed overflow
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module FixedPointAddUnit #(
    parameter int DataWidth = FixedPointPkg::DefaultDataWidth
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [DataWidth-1:0]  a,        // Signed operand A
    input  logic [DataWidth-1:0]  b,        // Signed operand B
    input  FixedPointPkg::opcodeE op,
    input  logic                  inValid,  // Capture strobe
    output logic [DataWidth-1:0]  result,
    output logic                  carryOut, // Unsigned carry of the adder
    output logic                  overflow, // Signed overflow
    output logic                  outValid  // Two cycles after inValid
);

    //------------------------------
    // Stage one to adder
    //------------------------------
    logic [DataWidth-1:0] prepA;
    logic [DataWidth-1:0] prepB;
    logic                 prepCarry;
    logic                 prepSat;
    logic                 prepSignA;
    logic                 prepValid;

    // Adder to stage two
    logic [DataWidth-1:0] sum;
    logic                 sumCarry;

    AddOperandPrep #(
        .DataWidth (DataWidth)
    ) uAddOperandPrep (
        .clk       (clk),
        .arstN     (arstN),
        .a         (a),
        .b         (b),
        .op        (op),
        .inValid   (inValid),
        .prepA     (prepA),
        .prepB     (prepB),
        .prepCarry (prepCarry),
        .prepSat   (prepSat),
        .prepSignA (prepSignA),
        .prepValid (prepValid)
    );

    // Combinational, settles within stage two
    StructuralRippleCarryAdd #(
        .N (DataWidth)
    ) uRippleCarryAdd (
        .a  (prepA),
        .b  (prepB),
        .ci (prepCarry),
        .c  (sum),
        .co (sumCarry)
    );

    AddResultStage #(
        .DataWidth (DataWidth)
    ) uAddResultStage (
        .clk       (clk),
        .arstN     (arstN),
        .prepA     (prepA),
        .prepB     (prepB),
        .sum       (sum),
        .sumCarry  (sumCarry),
        .prepSat   (prepSat),
        .prepSignA (prepSignA),
        .prepValid (prepValid),
        .result    (result),
        .carryOut  (carryOut),
        .overflow  (overflow),
        .outValid  (outValid)
    );

endmodule : FixedPointAddUnit

`default_nettype wire

// File: verif/FixedPointAddUnitTb.sv
//------------------------------
// Fixed-point add unit testbench
// Golden vectors with random idle gaps and value and latency checks
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module FixedPointAddUnitTb;

    localparam int DataWidth = FixedPointPkg::DefaultDataWidth;
    localparam int Latency   = 2;  // Cycles from capture to outValid
    localparam string GoldenFile = "verif/FixedPointAddUnitGolden.txt";

    //------------------------------
    // DUT signals
    //------------------------------
    logic                  clk;
    logic                  arstN;
    logic [DataWidth-1:0]  a;
    logic [DataWidth-1:0]  b;
    FixedPointPkg::opcodeE op;
    logic                  inValid;
    logic [DataWidth-1:0]  result;
    logic                  carryOut;
    logic                  overflow;
    logic                  outValid;

    // Golden vectors with one entry per file line
    logic [1:0]           vecOp[$];
    logic [DataWidth-1:0] vecA[$];
    logic [DataWidth-1:0] vecB[$];
    logic [DataWidth-1:0] vecRes[$];
    logic                 vecCarry[$];
    logic                 vecOvf[$];

    int   pendingQ[$];      // Vector indices in flight
    logic [Latency-1:0] validHist;  // inValid as seen at the last Latency edges
    int   pendIdx;
    int   valueErrors  = 0;
    int   timingErrors = 0;
    int   setupErrors  = 0;
    int   checkedCount = 0;
    int   cycleCount   = 0;
    int   timeoutLimit = 0;

    FixedPointAddUnit #(
        .DataWidth (DataWidth)
    ) dut (
        .clk      (clk),
        .arstN    (arstN),
        .a        (a),
        .b        (b),
        .op       (op),
        .inValid  (inValid),
        .result   (result),
        .carryOut (carryOut),
        .overflow (overflow),
        .outValid (outValid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    //------------------------------
    // Compare tasks
    //------------------------------
    task automatic checkData(input string name, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("error at %0t ns: %s expected %b got %b", $time, name, expected, actual);
        end
    endtask

    //------------------------------
    // Output monitor
    //------------------------------
    // Registered outputs read at the edge are the values before it
    always @(posedge clk) begin
        if (!arstN) begin
            validHist <= '0;
        end else begin
            validHist <= {validHist[Latency-2:0], inValid};
            // Pulse due Latency edges after the capture edge
            if (outValid !== validHist[Latency-1]) begin
                timingErrors++;
                if (outValid === 1'b1)
                    $display("Output valid at %0t ns without a vector due", $time);
                else
                    $display("Output valid missing or unknown at %0t ns", $time);
            end
            if (outValid === 1'b1) begin
                if (pendingQ.size() == 0) begin
                    timingErrors++;
                    $display("Output valid at %0t ns with no vector in flight", $time);
                end else begin
                    pendIdx = pendingQ.pop_front();
                    checkData("result", vecRes[pendIdx], result);
                    checkFlag("carryOut", vecCarry[pendIdx], carryOut);
                    checkFlag("overflow", vecOvf[pendIdx], overflow);
                    checkedCount++;
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, %0d vectors still in flight",
                     cycleCount, pendingQ.size());
            $display("Result: FAILED");
            $finish;
        end
    end

    //------------------------------
    // Stimulus
    //------------------------------
    initial begin
        int                   fd;
        int                   code;
        int                   fields;
        int                   gap;
        string                line;
        logic [DataWidth-1:0] fOp;
        logic [DataWidth-1:0] fA;
        logic [DataWidth-1:0] fB;
        logic [DataWidth-1:0] fRes;
        logic [DataWidth-1:0] fCarry;
        logic [DataWidth-1:0] fOvf;

        arstN   = 1'b0;
        a       = '0;
        b       = '0;
        op      = FixedPointPkg::OpAdd;
        inValid = 1'b0;
        void'($urandom(32'h1124de5f));

        fd = $fopen(GoldenFile, "r");
        if (fd == 0) begin
            setupErrors++;
            $display("Could not open golden file %s", GoldenFile);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // Skip blank and comment lines
                if (code > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h", fOp, fA, fB, fRes, fCarry, fOvf);
                    if (fields == 6) begin
                        vecOp.push_back(fOp[1:0]);
                        vecA.push_back(fA);
                        vecB.push_back(fB);
                        vecRes.push_back(fRes);
                        vecCarry.push_back(fCarry[0]);
                        vecOvf.push_back(fOvf[0]);
                    end
                end
            end
            $fclose(fd);
        end
        if (vecA.size() == 0) begin
            setupErrors++;
            $display("Golden file holds no vectors");
        end
        timeoutLimit = vecA.size() * 6 + 10 + 20;

        repeat (10) @(posedge clk); // Reset held for 10 cycles
        arstN <= 1'b1;

        for (int i = 0; i < vecA.size(); i++) begin
            gap = $urandom % 4; // 0 gives back-to-back vectors
            if (gap != 0) begin
                inValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            a       <= vecA[i];
            b       <= vecB[i];
            op      <= FixedPointPkg::opcodeE'(vecOp[i]);
            inValid <= 1'b1;
            pendingQ.push_back(i);
            @(posedge clk);
        end
        inValid <= 1'b0;

        // Drain then watch for stray pulses
        while (pendingQ.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);

        if (checkedCount != vecA.size())
            $display("Only %0d of %0d vectors produced an output", checkedCount, vecA.size());
        $display("Errors: value %0d, timing %0d, setup %0d, checked %0d of %0d vectors",
                 valueErrors, timingErrors, setupErrors, checkedCount, vecA.size());
        if (valueErrors == 0 && timingErrors == 0 && setupErrors == 0 &&
            checkedCount == vecA.size()) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : FixedPointAddUnitTb

`default_nettype wire

// File: verif/FixedPointAddUnitGolden.txt
// op a b result carry overflow, all hex
// op 0 add, 1 sub, 2 saturating add, 3 saturating sub
0 0000 0000 0000 0 0
0 0001 0001 0002 0 0
0 1234 4321 5555 0 0
0 7FFF 0001 8000 0 1
0 FFFF 0001 0000 1 0
0 8000 8000 0000 1 1
0 FFFF FFFF FFFE 1 0
0 4000 4000 8000 0 1
0 C000 C000 8000 1 0
0 00FF FF01 0000 1 0
0 ABCD 1234 BE01 0 0
0 7000 1000 8000 0 1
0 8001 FFFF 8000 1 0
1 0000 0000 0000 1 0
1 0005 0003 0002 1 0
1 0003 0005 FFFE 0 0
1 8000 0001 7FFF 1 1
1 7FFF FFFF 8000 0 1
1 FFFF FFFF 0000 1 0
1 1234 0234 1000 1 0
1 0000 8000 8000 0 1
1 8000 8000 0000 1 0
1 C000 4001 7FFF 1 1
1 4000 C000 8000 0 1
1 FFFE 0001 FFFD 1 0
2 7FFF 0001 7FFF 0 1
2 8000 FFFF 8000 1 1
2 1000 2000 3000 0 0
2 6000 6000 7FFF 0 1
2 A000 A000 8000 1 1
2 FFFF 0002 0001 1 0
3 8000 0001 8000 1 1
3 7FFF FFFF 7FFF 0 1
3 0000 8000 7FFF 0 1
3 0010 0020 FFF0 0 0
3 C000 4001 8000 1 1
3 0100 0080 0080 1 0

// File: FixedPointAddUnit.f
common/FixedPointPkg.sv
StructuralRippleCarryAdd/StructuralFullAdd.sv
StructuralRippleCarryAdd/StructuralRippleCarryAdd.sv
hdl/AddOperandPrep.sv
hdl/AddResultStage.sv
hdl/FixedPointAddUnit.sv
verif/FixedPointAddUnitTb.sv

// File: Bender.yml
package:
  name: fixed_point_add_unit

sources:
  # Shared package first
  - common/FixedPointPkg.sv
  # Adder chain
  - StructuralRippleCarryAdd/StructuralFullAdd.sv
  - StructuralRippleCarryAdd/StructuralRippleCarryAdd.sv
  # Pipeline stages and top level
  - hdl/AddOperandPrep.sv
  - hdl/AddResultStage.sv
  - hdl/FixedPointAddUnit.sv
  # Testbench
  - target: test
    files:
      - verif/FixedPointAddUnitTb.sv
